/* ecc_mem_top.f */
ecc_pkg.sv
ecc_mem_ctrl.sv
ecc_wr_path.sv
ecc_store.sv
ecc_rd_path.sv
ecc_err_log.sv
ecc_mem_top.sv
ecc_mem_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the testbench; the exit status is the verdict.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module ecc_mem_tb \
    -f ecc_mem_top.f -o ecc_mem_sim \
    && ./obj_dir/ecc_mem_sim \
    || exit 1

/* ecc_mem_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module ecc_mem_tb;
    import ecc_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int N_OPS   = 400;

    logic     clk;
    logic     arst_n;
    logic     req;
    ecc_req_t req_data;
    logic     ack;
    ecc_rsp_t rsp;
    ecc_log_t log;
    integer   seed;

    // Reference model of the array and the log.
    ecc_word_t         mdl_word [DEPTH];
    logic [DATA_W-1:0] mdl_orig [DEPTH];
    int                mdl_nflip [DEPTH];
    ecc_rsp_t          exp_rsp;
    ecc_log_t          exp_log;

    ecc_mem_top dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp      (rsp),
        .log      (log)
    );

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_rsp(input ecc_rsp_t exp, input ecc_rsp_t got);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: rsp expected %h got %h", $time, exp, got));
        end
    endtask

    task automatic check_log(input ecc_log_t exp, input ecc_log_t got);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: log expected %h got %h", $time, exp, got));
        end
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        int r;
        r = $random(seed);
        return $unsigned(r) % n;
    endfunction

    function automatic logic [DATA_W-1:0] rand_data();
        logic [63:0] w;
        w = {$random(seed), $random(seed)};
        return w[DATA_W-1:0];
    endfunction

    // Kind 0 clean, 1 data bit, 2 check bit, 3 two distinct bits.
    function automatic logic [CODE_W-1:0] make_flip(input int kind);
        int                b1;
        int                b2;
        logic [CODE_W-1:0] f;
        f = '0;
        if (kind == 1) begin
            b1 = rand_below(DATA_W);
            f[b1] = 1'b1;
        end else if (kind == 2) begin
            b1 = DATA_W + rand_below(CHECK_W);
            f[b1] = 1'b1;
        end else if (kind == 3) begin
            b1 = rand_below(CODE_W);
            b2 = (b1 + 1 + rand_below(CODE_W - 1)) % CODE_W;
            f[b1] = 1'b1;
            f[b2] = 1'b1;
        end
        return f;
    endfunction

    // One four-phase handshake, checked at every falling edge.
    task automatic run_txn(input ecc_req_t r);
        int cnt;
        int hold;
        bit seen;
        req_data = r;
        req      = 1'b1;
        seen = 1'b0;
        cnt  = 0;
        while (!seen && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
            seen = (ack === 1'b1);
        end
        if (!seen) begin
            abort_run("Timeout: ack did not rise after req was raised");
        end
        check_rsp(exp_rsp, rsp);
        check_log(exp_log, log);
        hold = rand_below(3);
        repeat (hold) begin
            @(negedge clk);
            if (ack !== 1'b1) begin
                abort_run("ack fell while req was still high");
            end
        end
        req  = 1'b0;
        seen = 1'b0;
        cnt  = 0;
        while (!seen && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
            seen = (ack === 1'b0);
        end
        if (!seen) begin
            abort_run("Timeout: ack did not fall after req was dropped");
        end
        hold = rand_below(3);
        repeat (hold) begin
            @(negedge clk);
            if (ack !== 1'b0) begin
                abort_run("ack rose with no request pending");
            end
        end
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [CODE_W-1:0] flip);
        ecc_req_t r;
        mdl_word[addr].data  = data ^ flip[DATA_W-1:0];
        mdl_word[addr].check = ecc_parity(data) ^ flip[CODE_W-1:DATA_W];
        mdl_orig[addr]       = data;
        mdl_nflip[addr]      = $countones(flip);
        r.op   = OP_WRITE;
        r.addr = addr;
        r.data = data;
        r.flip = flip;
        run_txn(r);
    endtask

    task automatic read_word(input logic [ADDR_W-1:0] addr, input bit raw);
        ecc_req_t r;
        exp_rsp.data     = mdl_word[addr].data;
        exp_rsp.check    = mdl_word[addr].check;
        exp_rsp.sbit_err = 1'b0;
        exp_rsp.dbit_err = 1'b0;
        if (!raw) begin
            // One flip is corrected, two are only flagged.
            if (mdl_nflip[addr] == 1) begin
                exp_rsp.data     = mdl_orig[addr];
                exp_rsp.sbit_err = 1'b1;
                exp_log.sbit_cnt = exp_log.sbit_cnt + 1'b1;
            end else if (mdl_nflip[addr] == 2) begin
                exp_rsp.dbit_err = 1'b1;
                exp_log.dbit_cnt = exp_log.dbit_cnt + 1'b1;
            end
            if (mdl_nflip[addr] != 0) begin
                exp_log.last_addr  = addr;
                exp_log.last_valid = 1'b1;
            end
        end
        r      = '0;
        r.op   = raw ? OP_READ_RAW : OP_READ;
        r.addr = addr;
        run_txn(r);
    endtask

    task automatic clear_log();
        ecc_req_t r;
        exp_log = '0;
        r       = '0;
        r.op    = OP_CLR_LOG;
        run_txn(r);
    endtask

    initial begin
        int                pick;
        logic [ADDR_W-1:0] addr;
        seed     = 62840;
        arst_n   = 1'b0;
        req      = 1'b0;
        req_data = '0;
        exp_rsp  = '0;
        exp_log  = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        if (ack !== 1'b0) begin
            abort_run("ack is not low after reset");
        end
        check_rsp(exp_rsp, rsp);
        check_log(exp_log, log);
        // Every address holds clean data before the mixed run.
        for (int a = 0; a < DEPTH; a++) begin
            write_word(ADDR_W'(a), rand_data(), '0);
        end
        for (int n = 0; n < N_OPS; n++) begin
            pick = rand_below(10);
            addr = ADDR_W'(rand_below(DEPTH));
            if (pick < 3) begin
                write_word(addr, rand_data(), make_flip(rand_below(4)));
            end else if (pick < 7) begin
                read_word(addr, 1'b0);
            end else if (pick < 9) begin
                read_word(addr, 1'b1);
            end else begin
                clear_log();
            end
        end
        clear_log();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* ecc_mem_top.sv */
`timescale 1ns/1ns
`default_nettype none

module ecc_mem_top (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     req,
    input  wire ecc_pkg::ecc_req_t  req_data,
    output wire                     ack,
    output wire ecc_pkg::ecc_rsp_t  rsp,
    output wire ecc_pkg::ecc_log_t  log
);
    import ecc_pkg::*;

    ecc_req_t          cur_req;
    logic              wr_en;
    logic              rd_en;
    logic              dec_en;
    logic              clr;
    logic              bypass;
    ecc_word_t         wr_word;
    logic [ADDR_W-1:0] wr_addr;
    logic              store_we;
    ecc_word_t         rd_word;
    logic              dec_done;
    logic              sbit_err;
    logic              dbit_err;

    ecc_mem_ctrl u_ctrl (
        .clk      (clk),
        .arst_n   (arst_n),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .cur_req  (cur_req),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .dec_en   (dec_en),
        .clr      (clr),
        .bypass   (bypass)
    );

    ecc_wr_path u_wr_path (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_en    (wr_en),
        .cur_req  (cur_req),
        .wr_word  (wr_word),
        .wr_addr  (wr_addr),
        .store_we (store_we)
    );

    ecc_store u_store (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_word  (wr_word),
        .wr_addr  (wr_addr),
        .store_we (store_we),
        .rd_en    (rd_en),
        .rd_addr  (cur_req.addr),
        .rd_word  (rd_word)
    );

    ecc_rd_path u_rd_path (
        .clk      (clk),
        .arst_n   (arst_n),
        .dec_en   (dec_en),
        .bypass   (bypass),
        .rd_word  (rd_word),
        .rsp      (rsp),
        .dec_done (dec_done),
        .sbit_err (sbit_err),
        .dbit_err (dbit_err)
    );

    ecc_err_log u_err_log (
        .clk      (clk),
        .arst_n   (arst_n),
        .clr      (clr),
        .dec_done (dec_done),
        .sbit_err (sbit_err),
        .dbit_err (dbit_err),
        .err_addr (cur_req.addr),
        .log      (log)
    );

endmodule

`default_nettype wire

/* ecc_err_log.sv */
`timescale 1ns/1ns
`default_nettype none

module ecc_err_log (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         clr,
    input  wire                         dec_done,
    input  wire                         sbit_err,
    input  wire                         dbit_err,
    input  wire [ecc_pkg::ADDR_W-1:0]   err_addr,
    output ecc_pkg::ecc_log_t           log
);
    import ecc_pkg::*;

    logic sbit_hit;
    logic dbit_hit;

    assign sbit_hit = dec_done && sbit_err;
    assign dbit_hit = dec_done && dbit_err;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            log <= '0;
        end else if (clr) begin
            log <= '0;
        end else begin
            // Counters stick at all ones.
            if (sbit_hit && log.sbit_cnt != {CNT_W{1'b1}}) begin
                log.sbit_cnt <= log.sbit_cnt + 1'b1;
            end
            if (dbit_hit && log.dbit_cnt != {CNT_W{1'b1}}) begin
                log.dbit_cnt <= log.dbit_cnt + 1'b1;
            end
            if (sbit_hit || dbit_hit) begin
                log.last_addr  <= err_addr;
                log.last_valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* ecc_rd_path.sv */
`timescale 1ns/1ns
`default_nettype none

module ecc_rd_path (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     dec_en,
    input  wire                     bypass,
    input  wire ecc_pkg::ecc_word_t rd_word,
    output ecc_pkg::ecc_rsp_t       rsp,
    output logic                    dec_done,
    output logic                    sbit_err,
    output logic                    dbit_err
);
    import ecc_pkg::*;

    logic [CHECK_W-1:0] syndrome;
    logic [DATA_W-1:0]  flip_mask;
    logic [DATA_W-1:0]  bit_sel;
    logic               sbit_det;
    logic               dbit_det;
    ecc_rsp_t           rsp_nxt;

    assign syndrome = rd_word.check ^ ecc_parity(rd_word.data);

    // Match the syndrome against every data-bit column.
    always_comb begin
        flip_mask = '0;
        bit_sel   = '0;
        for (int i = 0; i < DATA_W; i++) begin
            bit_sel    = '0;
            bit_sel[i] = 1'b1;
            if (syndrome == ecc_parity(bit_sel)) begin
                flip_mask[i] = 1'b1;
            end
        end
    end

    always_comb begin
        sbit_det = 1'b0;
        dbit_det = 1'b0;
        if (syndrome != '0) begin
            // Single bit set means the check bit itself flipped.
            if (flip_mask != '0 || $onehot(syndrome)) begin
                sbit_det = 1'b1;
            end else begin
                dbit_det = 1'b1;
            end
        end
    end

    always_comb begin
        rsp_nxt.check = rd_word.check;
        if (bypass) begin
            rsp_nxt.data     = rd_word.data;
            rsp_nxt.sbit_err = 1'b0;
            rsp_nxt.dbit_err = 1'b0;
        end else begin
            rsp_nxt.data     = rd_word.data ^ flip_mask;
            rsp_nxt.sbit_err = sbit_det;
            rsp_nxt.dbit_err = dbit_det;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp      <= '0;
            dec_done <= 1'b0;
        end else begin
            dec_done <= dec_en;
            if (dec_en) begin
                rsp <= rsp_nxt;
            end
        end
    end

    // Flags qualify with dec_done at the log.
    assign sbit_err = rsp.sbit_err;
    assign dbit_err = rsp.dbit_err;

endmodule

`default_nettype wire

/* ecc_store.sv */
`timescale 1ns/1ns
`default_nettype none

module ecc_store (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire ecc_pkg::ecc_word_t     wr_word,
    input  wire [ecc_pkg::ADDR_W-1:0]   wr_addr,
    input  wire                         store_we,
    input  wire                         rd_en,
    input  wire [ecc_pkg::ADDR_W-1:0]   rd_addr,
    output ecc_pkg::ecc_word_t          rd_word
);
    import ecc_pkg::*;

    ecc_word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (store_we) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // Registered read port.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_word <= '0;
        end else if (rd_en) begin
            rd_word <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* ecc_wr_path.sv */
`timescale 1ns/1ns
`default_nettype none

module ecc_wr_path (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         wr_en,
    input  wire ecc_pkg::ecc_req_t      cur_req,
    output ecc_pkg::ecc_word_t          wr_word,
    output logic [ecc_pkg::ADDR_W-1:0]  wr_addr,
    output logic                        store_we
);
    import ecc_pkg::*;

    ecc_word_t enc_word;

    // Injected errors are applied after encoding.
    always_comb begin
        enc_word.data  = cur_req.data ^ cur_req.flip[DATA_W-1:0];
        enc_word.check = ecc_parity(cur_req.data) ^ cur_req.flip[CODE_W-1:DATA_W];
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            wr_word <= enc_word;
            wr_addr <= cur_req.addr;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            store_we <= 1'b0;
        end else begin
            store_we <= wr_en;
        end
    end

endmodule

`default_nettype wire

/* ecc_mem_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module ecc_mem_ctrl (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 req,
    input  wire ecc_pkg::ecc_req_t req_data,
    output logic                ack,
    output ecc_pkg::ecc_req_t   cur_req,
    output logic                wr_en,
    output logic                rd_en,
    output logic                dec_en,
    output logic                clr,
    output logic                bypass
);
    import ecc_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        ENC,
        STORE,
        RD,
        DEC,
        DONE,
        WAIT_LOW
    } state_e;

    state_e state;
    state_e state_nxt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Request is held for the whole transaction.
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            cur_req <= req_data;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req) begin
                    case (req_data.op)
                        OP_WRITE:    state_nxt = ENC;
                        OP_READ:     state_nxt = RD;
                        OP_READ_RAW: state_nxt = RD;
                        default:     state_nxt = DONE;
                    endcase
                end
            end
            ENC:   state_nxt = STORE;
            STORE: state_nxt = WAIT_LOW;
            RD:    state_nxt = DEC;
            DEC:   state_nxt = DONE;
            // Log settles here before ack goes up.
            DONE:  state_nxt = WAIT_LOW;
            WAIT_LOW: begin
                if (!req) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    assign ack    = (state == WAIT_LOW);
    assign wr_en  = (state == ENC);
    assign rd_en  = (state == RD);
    assign dec_en = (state == DEC);
    assign clr    = (state == DONE) && (cur_req.op == OP_CLR_LOG);
    assign bypass = (cur_req.op == OP_READ_RAW);

endmodule

`default_nettype wire

/* ecc_pkg.sv */
`default_nettype none

package ecc_pkg;

    localparam int DATA_W  = 50;
    localparam int CHECK_W = 7;
    localparam int CODE_W  = DATA_W + CHECK_W;
    localparam int DEPTH   = 16;
    localparam int ADDR_W  = 4;
    localparam int CNT_W   = 16;

    typedef enum logic [1:0] {
        OP_WRITE    = 2'd0,
        OP_READ     = 2'd1,
        OP_READ_RAW = 2'd2,
        OP_CLR_LOG  = 2'd3
    } ecc_op_e;

    // Flip bits 49..0 hit data, 56..50 hit check bits.
    typedef struct packed {
        ecc_op_e             op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data;
        logic [CODE_W-1:0]   flip;
    } ecc_req_t;

    typedef struct packed {
        logic [DATA_W-1:0]   data;
        logic [CHECK_W-1:0]  check;
    } ecc_word_t;

    typedef struct packed {
        logic [DATA_W-1:0]   data;
        logic [CHECK_W-1:0]  check;
        logic                sbit_err;
        logic                dbit_err;
    } ecc_rsp_t;

    typedef struct packed {
        logic [CNT_W-1:0]    sbit_cnt;
        logic [CNT_W-1:0]    dbit_cnt;
        logic [ADDR_W-1:0]   last_addr;
        logic                last_valid;
    } ecc_log_t;

    // Check bits of the 50-bit SEC-DED code.
    function automatic logic [CHECK_W-1:0] ecc_parity(input logic [DATA_W-1:0] d);
        logic [CHECK_W-1:0] p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[11] ^ d[13] ^ d[15]
             ^ d[17] ^ d[19] ^ d[21] ^ d[23] ^ d[25] ^ d[26] ^ d[28] ^ d[30] ^ d[32]
             ^ d[34] ^ d[36] ^ d[38] ^ d[40] ^ d[42] ^ d[44] ^ d[46] ^ d[48];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^ d[12] ^ d[13] ^ d[16]
             ^ d[17] ^ d[20] ^ d[21] ^ d[24] ^ d[25] ^ d[27] ^ d[28] ^ d[31] ^ d[32]
             ^ d[35] ^ d[36] ^ d[39] ^ d[40] ^ d[43] ^ d[44] ^ d[47] ^ d[48];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[14] ^ d[15] ^ d[16]
             ^ d[17] ^ d[22] ^ d[23] ^ d[24] ^ d[25] ^ d[29] ^ d[30] ^ d[31] ^ d[32]
             ^ d[37] ^ d[38] ^ d[39] ^ d[40] ^ d[45] ^ d[46] ^ d[47] ^ d[48];
        p[3] = (^d[10:4]) ^ (^d[25:18]) ^ (^d[40:33]) ^ d[49];
        p[4] = (^d[25:11]) ^ (^d[49:41]);
        p[5] = ^d[49:26];
        p[6] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[12] ^ d[14]
             ^ d[17] ^ d[18] ^ d[21] ^ d[23] ^ d[24] ^ d[26] ^ d[27] ^ d[29] ^ d[32]
             ^ d[33] ^ d[36] ^ d[38] ^ d[39] ^ d[41] ^ d[44] ^ d[46] ^ d[47];
        return p;
    endfunction

endpackage

`default_nettype wire
